// ==== all.f ====
rtl/minerPkg.sv
rtl/blockStore.sv
rtl/hashCore.sv
rtl/resultArbiter.sv
rtl/nonceBuffer.sv
rtl/minerTop.sv
tb/minerTop_sva.sv
tb/minerTb.sv

// ==== tb/minerTb.sv ====
`timescale 1ns/1ps

module minerTb import minerPkg::*; ();

	localparam int TIMEOUT_CYCLES = 6 * (SEARCH_SPAN / NUM_CORES * 9 + 200);
	localparam logic [31:0] QUARTER_TARGET = 32'h4000_0000;
	localparam logic [31:0] MAX_TARGET = 32'hffff_ffff;

	logic clk;
	logic reset_i;
	logic blkValid_i;
	blockHeader_t blkHeader_i;
	logic readReady_i;
	logic resultValid_o;
	hitResult_t result_o;
	logic error_o;
	logic searchDone_o;

	hitResult_t expected [$]; // hits not yet seen for the current job
	logic seen [SEARCH_SPAN];
	logic checking;
	int popCount;
	int valueErrors;
	int hitErrors;
	int cycleCount;

	minerTop minerTop_i (
		.clk,
		.reset_i,
		.blkValid_i,
		.blkHeader_i,
		.readReady_i,
		.resultValid_o,
		.result_o,
		.error_o,
		.searchDone_o
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// eight add-rotate-xor rounds over data ^ nonce
	function automatic logic [31:0] refHash(input logic [31:0] data, input logic [31:0] nonce);
		logic [31:0] s;
		logic [31:0] rot;
		s = data ^ nonce;
		for (int r = 0; r < ROUNDS; r++) begin
			rot = {s[26:0], s[31:27]};
			s = (rot + (s ^ ROUND_CONST[r])) ^ data;
		end
		return s;
	endfunction

	function automatic void collectHits(input blockHeader_t hdr);
		expected.delete();
		foreach (seen[k]) seen[k] = 1'b0;
		for (int n = 0; n < SEARCH_SPAN; n++) begin
			if (refHash(hdr.data, 32'(n)) < hdr.target) begin
				expected.push_back('{nonce: 32'(n), tag: hdr.tag});
			end
		end
	endfunction

	function automatic blockHeader_t makeHeader(input logic [3:0] tag, input logic [31:0] target);
		blockHeader_t hdr;
		hdr.data = $urandom();
		hdr.target = target;
		hdr.tag = tag;
		return hdr;
	endfunction

	task automatic checkResult(input string name, input hitResult_t exp, input hitResult_t act);
		if (act !== exp) begin
			$display("CHECK FAILED @ %0t: %s expected nonce %h tag %h, got nonce %h tag %h",
				$time, name, exp.nonce, exp.tag, act.nonce, act.tag);
			valueErrors++;
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED @ %0t: %s expected %b, got %b", $time, name, exp, act);
			valueErrors++;
		end
	endtask

	task automatic matchResult(input hitResult_t got);
		int idx;
		idx = -1;
		foreach (expected[k]) begin
			if (expected[k].nonce == got.nonce) idx = k;
		end
		if (idx < 0) begin
			hitErrors++;
			if (got.nonce < SEARCH_SPAN && seen[got.nonce]) begin
				$display("duplicate hit at %0t: nonce %h was reported twice", $time, got.nonce);
			end else begin
				$display("unexpected hit at %0t: nonce %h is not in the reference set",
					$time, got.nonce);
			end
		end else begin
			checkResult("result_o", expected[idx], got);
			seen[got.nonce] = 1'b1;
			expected.delete(idx);
		end
	endtask

	task automatic checkMissing();
		foreach (expected[k]) begin
			$display("missing hit: nonce %h with tag %h was never reported",
				expected[k].nonce, expected[k].tag);
			hitErrors++;
		end
		expected.delete();
	endtask

	// sampled mid-cycle before the pop edge
	always @(negedge clk) begin
		if (resultValid_o && readReady_i) begin
			popCount++;
			if (checking) matchResult(result_o);
		end
	end

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic sendJob(input blockHeader_t hdr);
		blkHeader_i = hdr;
		blkValid_i = 1'b1;
		tick();
		blkValid_i = 1'b0;
	endtask

	task automatic waitDone();
		while (!searchDone_o) tick();
	endtask

	task automatic drain();
		repeat (3) tick(); // last grant still on the bus
		while (resultValid_o) tick();
		tick();
	endtask

	task automatic runJob(input blockHeader_t hdr);
		collectHits(hdr);
		popCount = 0;
		checking = 1'b1;
		readReady_i = 1'b1;
		sendJob(hdr);
		repeat (2) tick();
		checkBit("searchDone_o", 1'b0, searchDone_o);
		waitDone();
		drain();
		checkMissing();
		checkBit("searchDone_o", 1'b1, searchDone_o);
	endtask

	initial begin
		cycleCount = 0;
		while (cycleCount < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		blockHeader_t hdr;
		void'($urandom(42));
		reset_i = 1'b1;
		blkValid_i = 1'b0;
		blkHeader_i = '0;
		readReady_i = 1'b0;
		checking = 1'b0;
		popCount = 0;
		valueErrors = 0;
		hitErrors = 0;
		repeat (4) @(posedge clk);
		#2;
		reset_i = 1'b0;
		checkBit("resultValid_o", 1'b0, resultValid_o);
		checkBit("error_o", 1'b0, error_o);
		checkBit("searchDone_o", 1'b0, searchDone_o);

		runJob(makeHeader(4'h1, QUARTER_TARGET)); // sparse hits
		checkBit("error_o", 1'b0, error_o);
		runJob(makeHeader(4'h2, MAX_TARGET)); // every core requests together
		checkBit("error_o", 1'b0, error_o);

		// overflow with the reader stalled for the whole search
		hdr = makeHeader(4'h3, MAX_TARGET);
		collectHits(hdr);
		while (expected.size() > BUF_DEPTH) void'(expected.pop_back());
		popCount = 0;
		readReady_i = 1'b0;
		sendJob(hdr);
		repeat (2) tick();
		waitDone();
		repeat (3) tick();
		checkBit("error_o", 1'b1, error_o);
		checkBit("resultValid_o", 1'b1, resultValid_o);
		readReady_i = 1'b1;
		drain();
		if (popCount != BUF_DEPTH) begin
			$display("overflow: %0d results were readable instead of %0d", popCount, BUF_DEPTH);
			hitErrors++;
		end
		checkMissing();
		checkBit("error_o", 1'b1, error_o);

		// restart mid-search with old results flushed unchecked
		checking = 1'b0;
		sendJob(makeHeader(4'h4, QUARTER_TARGET));
		repeat (200) tick();
		checkBit("searchDone_o", 1'b0, searchDone_o);
		hdr = makeHeader(4'h5, QUARTER_TARGET);
		sendJob(hdr);
		repeat (6) tick();
		collectHits(hdr);
		popCount = 0;
		checking = 1'b1;
		waitDone();
		drain();
		checkMissing();

		// reset in the middle of a job with hits queued
		checking = 1'b0;
		readReady_i = 1'b0;
		sendJob(makeHeader(4'h6, QUARTER_TARGET));
		repeat (100) tick();
		reset_i = 1'b1;
		repeat (4) tick();
		reset_i = 1'b0;
		tick();
		checkBit("resultValid_o", 1'b0, resultValid_o);
		checkBit("error_o", 1'b0, error_o);
		repeat (CORE_SPAN * (ROUNDS + 1)) tick(); // long enough to finish a job
		checkBit("searchDone_o", 1'b0, searchDone_o);

		$display("errors: %0d value mismatches, %0d hit-set errors, %0d assertion failures",
			valueErrors, hitErrors, minerTop_i.sva.failCount);
		if (valueErrors == 0 && hitErrors == 0 && minerTop_i.sva.failCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// ==== tb/minerTop_sva.sv ====
`timescale 1ns/1ps

module minerTopSva import minerPkg::*; (
	input logic clk,
	input logic reset_i,
	input logic newJob_i,
	input logic [NUM_CORES-1:0] hitReq_i,
	input logic [NUM_CORES-1:0] grant_i,
	input logic resultValid_i,
	input hitResult_t result_i,
	input logic readReady_i,
	input logic error_i
);

	int failCount = 0; // assertion failures so far

	assert property (@(posedge clk) disable iff (reset_i) $onehot0(grant_i))
		else begin
			failCount++;
			$error("arbiter granted more than one core");
		end

	assert property (@(posedge clk) disable iff (reset_i) (grant_i & ~hitReq_i) == '0)
		else begin
			failCount++;
			$error("grant given to a core that did not request");
		end

	// a new job may drop a pending request
	for (genvar i = 0; i < NUM_CORES; i++) begin : reqHold
		assert property (@(posedge clk) disable iff (reset_i)
			hitReq_i[i] && !grant_i[i] && !newJob_i |=> hitReq_i[i])
			else begin
				failCount++;
				$error("core %0d dropped its request before a grant", i);
			end
	end

	assert property (@(posedge clk) disable iff (reset_i)
		resultValid_i && !readReady_i |=> resultValid_i && $stable(result_i))
		else begin
			failCount++;
			$error("buffer head changed while not read");
		end

	assert property (@(posedge clk) $fell(error_i) |-> $past(reset_i))
		else begin
			failCount++;
			$error("overflow flag cleared without a reset");
		end

endmodule

bind minerTop minerTopSva sva (
	.clk(clk),
	.reset_i(reset_i),
	.newJob_i(newJob),
	.hitReq_i(hitReq),
	.grant_i(grant),
	.resultValid_i(resultValid_o),
	.result_i(result_o),
	.readReady_i(readReady_i),
	.error_i(error_o)
);

// ==== rtl/minerTop.sv ====
`timescale 1ns/1ps

module minerTop import minerPkg::*; (
	input logic clk,
	input logic reset_i,
	input logic blkValid_i,
	input blockHeader_t blkHeader_i,
	input logic readReady_i,
	output logic resultValid_o,
	output hitResult_t result_o,
	output logic error_o,
	output logic searchDone_o
);

	blockHeader_t header;
	logic newJob;
	logic [NUM_CORES-1:0] hitReq;
	logic [NUM_CORES-1:0] grant;
	logic [NUM_CORES-1:0] coreDone;
	hitResult_t [NUM_CORES-1:0] hits;
	logic busValid;
	hitResult_t busResult;

	blockStore blkStore (
		.clk,
		.reset_i,
		.blkValid_i,
		.blkHeader_i,
		.header_o(header),
		.newJob_o(newJob)
	);

	// peer cores, each on its own nonce stride
	generate
		for (genvar i = 0; i < NUM_CORES; i++) begin : cores
			hashCore #(.CORE_INDEX(i)) core (
				.clk,
				.reset_i,
				.header_i(header),
				.newJob_i(newJob),
				.grant_i(grant[i]),
				.hitReq_o(hitReq[i]),
				.hit_o(hits[i]),
				.done_o(coreDone[i])
			);
		end
	endgenerate

	resultArbiter arbiter (
		.clk,
		.reset_i,
		.hitReq_i(hitReq),
		.hits_i(hits),
		.grant_o(grant),
		.busValid_o(busValid),
		.busResult_o(busResult)
	);

	nonceBuffer nonBuf (
		.clk,
		.reset_i,
		.push_i(busValid),
		.pushData_i(busResult),
		.readReady_i,
		.valid_o(resultValid_o),
		.data_o(result_o),
		.error_o
	);

	assign searchDone_o = &coreDone; // all cores finished

endmodule

// ==== rtl/nonceBuffer.sv ====
`timescale 1ns/1ps

module nonceBuffer import minerPkg::*; (
	input logic clk,
	input logic reset_i,
	input logic push_i,
	input hitResult_t pushData_i,
	input logic readReady_i,
	output logic valid_o,
	output hitResult_t data_o,
	output logic error_o
);

	hitResult_t mem [BUF_DEPTH];
	logic [BUF_PTR_W-1:0] rdPtr;
	logic [BUF_PTR_W-1:0] wrPtr;
	logic [BUF_PTR_W:0] count;
	logic full;
	logic pop;
	logic accept;

	assign full = count == (BUF_PTR_W + 1)'(BUF_DEPTH);
	assign pop = readReady_i && valid_o;
	assign accept = push_i && (!full || pop); // slot freed by same-cycle pop

	always_ff @(posedge clk) begin
		if (accept) begin
			mem[wrPtr] <= pushData_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			error_o <= 1'b0;
		end else begin
			if (accept) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({accept, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push_i && !accept) begin
				error_o <= 1'b1; // sticky until reset
			end
		end
	end

	// head shown without read delay
	assign valid_o = count != '0;
	assign data_o = mem[rdPtr];

endmodule

// ==== rtl/resultArbiter.sv ====
`timescale 1ns/1ps

module resultArbiter import minerPkg::*; (
	input logic clk,
	input logic reset_i,
	input logic [NUM_CORES-1:0] hitReq_i,
	input hitResult_t [NUM_CORES-1:0] hits_i,
	output logic [NUM_CORES-1:0] grant_o,
	output logic busValid_o,
	output hitResult_t busResult_o
);

	logic [CORE_IDX_W-1:0] lastGrant;
	logic [CORE_IDX_W-1:0] grantIdx;
	logic [CORE_IDX_W-1:0] cand;
	logic found;

	// search starts one past the last winner, ends on it
	always_comb begin
		grant_o = '0;
		grantIdx = lastGrant;
		cand = lastGrant;
		found = 1'b0;
		for (int i = 1; i <= NUM_CORES; i++) begin
			cand = lastGrant + CORE_IDX_W'(i);
			if (!found && hitReq_i[cand]) begin
				found = 1'b1;
				grantIdx = cand;
			end
		end
		if (found) begin
			grant_o[grantIdx] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			busValid_o <= 1'b0;
			lastGrant <= CORE_IDX_W'(NUM_CORES - 1); // core 0 first
		end else begin
			busValid_o <= found;
			if (found) begin
				lastGrant <= grantIdx;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			busResult_o <= hits_i[grantIdx];
		end
	end

endmodule

// ==== rtl/hashCore.sv ====
`timescale 1ns/1ps

module hashCore import minerPkg::*; #(
	parameter int CORE_INDEX = 0
) (
	input logic clk,
	input logic reset_i,
	input blockHeader_t header_i,
	input logic newJob_i,
	input logic grant_i,
	output logic hitReq_o,
	output hitResult_t hit_o,
	output logic done_o
);

	localparam logic [31:0] FIRST_NONCE = CORE_INDEX;
	localparam logic [31:0] LAST_NONCE = CORE_INDEX + (CORE_SPAN - 1) * NUM_CORES;
	localparam logic [ROUND_W-1:0] LAST_ROUND = ROUND_W'(ROUNDS - 1);

	coreState_e state;
	logic [31:0] nonce;
	logic [31:0] mixState;
	logic [31:0] mixNext;
	logic [ROUND_W-1:0] round;
	logic [3:0] jobTag;
	logic lastRound;
	logic isHit;
	logic lastNonce;
	logic advance;

	assign mixNext = mixRound(mixState, round, header_i.data);
	assign lastRound = round == LAST_ROUND;
	assign isHit = mixNext < header_i.target;
	assign lastNonce = nonce == LAST_NONCE;

	// current nonce finished, either a miss or a granted hit
	assign advance = (state == MIX && lastRound && !isHit) || (state == REPORT && grant_i);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state <= IDLE;
		end else if (newJob_i) begin
			state <= LOAD; // restart drops any pending hit
		end else begin
			case (state)
				LOAD: begin
					state <= MIX;
				end
				MIX: begin
					if (lastRound && isHit) begin
						state <= REPORT;
					end else if (advance) begin
						state <= lastNonce ? DONE : LOAD;
					end
				end
				REPORT: begin
					if (advance) begin
						state <= lastNonce ? DONE : LOAD;
					end
				end
				default: begin
					state <= state; // IDLE and DONE wait for a job
				end
			endcase
		end
	end

	// nonce walk, stride of NUM_CORES
	always_ff @(posedge clk) begin
		if (newJob_i) begin
			nonce <= FIRST_NONCE;
			jobTag <= header_i.tag;
		end else if (advance && !lastNonce) begin
			nonce <= nonce + NUM_CORES;
		end
	end

	always_ff @(posedge clk) begin
		if (state == LOAD) begin
			mixState <= header_i.data ^ nonce;
			round <= '0;
		end else if (state == MIX) begin
			mixState <= mixNext;
			round <= round + 1'b1;
		end
	end

	assign hitReq_o = state == REPORT;
	assign hit_o = '{nonce: nonce, tag: jobTag};
	assign done_o = state == DONE;

endmodule

// ==== rtl/blockStore.sv ====
`timescale 1ns/1ps

module blockStore import minerPkg::*; (
	input logic clk,
	input logic reset_i,
	input logic blkValid_i,
	input blockHeader_t blkHeader_i,
	output blockHeader_t header_o,
	output logic newJob_o
);

	blockHeader_t header;
	logic newJob;

	// header held until the next strobe
	always_ff @(posedge clk) begin
		if (blkValid_i) begin
			header <= blkHeader_i;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			newJob <= 1'b0;
		end else begin
			newJob <= blkValid_i; // one pulse per strobe
		end
	end

	assign header_o = header;
	assign newJob_o = newJob;

endmodule

// ==== rtl/minerPkg.sv ====
package minerPkg;

	localparam int NUM_CORES = 4; // power of two
	localparam int ROUNDS = 8;
	localparam int SEARCH_SPAN = 256;
	localparam int BUF_DEPTH = 8;

	localparam int CORE_SPAN = SEARCH_SPAN / NUM_CORES; // nonces per core
	localparam int CORE_IDX_W = $clog2(NUM_CORES);
	localparam int ROUND_W = $clog2(ROUNDS);
	localparam int BUF_PTR_W = $clog2(BUF_DEPTH);

	typedef struct packed {
		logic [31:0] data;
		logic [31:0] target; // hit when hash < target
		logic [3:0] tag;
	} blockHeader_t;

	typedef struct packed {
		logic [31:0] nonce;
		logic [3:0] tag;
	} hitResult_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		MIX,
		REPORT,
		DONE
	} coreState_e;

	localparam logic [31:0] ROUND_CONST [ROUNDS] = '{
		32'h428a2f98,
		32'h71374491,
		32'hb5c0fbcf,
		32'he9b5dba5,
		32'h3956c25b,
		32'h59f111f1,
		32'h923f82a4,
		32'hab1c5ed5
	};

	// one add-rotate-xor round
	function automatic logic [31:0] mixRound(
		input logic [31:0] state,
		input logic [ROUND_W-1:0] round,
		input logic [31:0] data
	);
		logic [31:0] rotated;
		logic [31:0] keyed;
		rotated = {state[26:0], state[31:27]};
		keyed = state ^ ROUND_CONST[round];
		return (rotated + keyed) ^ data;
	endfunction

endpackage
